// File: verilog/udp_tx_pkg.sv
package udp_tx_pkg;

    //////////////////////////////////////////////////
    // frame constants

    localparam logic [7:0]  preamble_byte = 8'h55;
    localparam logic [7:0]  sfd_byte      = 8'hd5;
    localparam logic [15:0] eth_type_ipv4 = 16'h0800;

    // fixed ipv4 header fields
    localparam logic [7:0]  ip_ver_ihl    = 8'h45;   // v4, 5 words
    localparam logic [7:0]  ip_tos        = 8'h00;
    localparam logic [15:0] ip_flags_frag = 16'h4000; // don't fragment
    localparam logic [7:0]  ip_ttl        = 8'h40;
    localparam logic [7:0]  ip_proto_udp  = 8'd17;

    // section sizes in bytes unless noted
    localparam int preamble_bytes    = 8;   // incl sfd
    localparam int eth_hdr_bytes     = 14;
    localparam int ip_hdr_bytes      = 20;
    localparam int udp_hdr_bytes     = 8;
    localparam int hdr_words         = 7;   // ip + udp in 32-bit words
    localparam int min_payload_bytes = 18;  // keeps the frame at 64 bytes
    localparam int fcs_nibbles       = 8;

    //////////////////////////////////////////////////
    // types

    typedef logic [15:0] len_t;
    typedef logic [2:0]  hdr_idx_t;

    // one header word, summed as halves or sent as bytes
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] half;   // [1] is the upper half
        logic [3:0][7:0]  bytes;  // [3] goes on the wire first
    } hdr_word_u;

    typedef enum logic [2:0] {
        idle,
        checksum,
        preamble,
        eth_hdr,
        ip_udp_hdr,
        payload,
        fcs
    } frame_state_e;

    // crc-32 as used for the ethernet fcs
    localparam logic [31:0] crc_poly = 32'h04c1_1db7;
    localparam logic [31:0] crc_init = 32'hffff_ffff;

endpackage

// File: verilog/udp_hdr_if.sv
interface udp_hdr_if import udp_tx_pkg::*; ();

    // from the sequencer
    logic      start;        // one cycle, new frame
    hdr_idx_t  hdr_idx;      // word being sent

    // from the header registers
    hdr_word_u hdr_word;     // word at hdr_idx
    len_t      payload_len;  // latched byte count
    logic      hdr_ready;    // checksum written, one cycle

    modport regs (
        input  start,
        input  hdr_idx,
        output hdr_word,
        output payload_len,
        output hdr_ready
    );

    modport seq (
        output start,
        output hdr_idx,
        input  hdr_word,
        input  payload_len,
        input  hdr_ready
    );

endinterface

// File: verilog/udp_crc_if.sv
interface udp_crc_if ();

    logic        crc_clr;     // back to the init value
    logic        crc_en;      // absorb crc_nibble this cycle
    logic [3:0]  crc_nibble;  // bit 0 is first on the wire
    logic [31:0] crc_value;

    modport seq (
        output crc_clr,
        output crc_en,
        output crc_nibble,
        input  crc_value
    );

    modport crc (
        input  crc_clr,
        input  crc_en,
        input  crc_nibble,
        output crc_value
    );

endinterface

// File: verilog/udp_hdr_regs.sv
module udp_hdr_regs import udp_tx_pkg::*; #(
    parameter logic [31:0] board_ip   = 32'hc0a8_0002,
    parameter logic [31:0] pc_ip      = 32'hc0a8_0001,
    parameter logic [15:0] board_port = 16'd1234,
    parameter logic [15:0] pc_port    = 16'd1234
) (
    input  logic   sys_clk,
    input  logic   sys_rst_n,
    input  len_t   send_data_num,
    udp_hdr_if.regs hdr
);

    hdr_word_u   words [hdr_words];  // ip header, then udp header
    len_t        ip_len;
    len_t        udp_len;
    logic [15:0] ident;              // identification field
    logic [2:0]  ck_step;            // sum, fold, write
    logic [19:0] sum_all;            // ten halves, carries kept
    logic [19:0] csum;

    assign ip_len  = send_data_num + len_t'(ip_hdr_bytes + udp_hdr_bytes);
    assign udp_len = send_data_num + len_t'(udp_hdr_bytes);

    //////////////////////////////////////////////////
    // control

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            ident         <= '0;
            ck_step       <= '0;
            hdr.hdr_ready <= 1'b0;
        end else begin
            ck_step       <= {ck_step[1:0], hdr.start};
            hdr.hdr_ready <= ck_step[2];  // same edge as the checksum write
            if (hdr.start) begin
                ident <= ident + 16'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // header words

    always_ff @(posedge sys_clk) begin
        if (hdr.start) begin
            hdr.payload_len <= send_data_num;
            words[0].word   <= {ip_ver_ihl, ip_tos, ip_len};
            words[1].word   <= {ident + 16'd1, ip_flags_frag};
            words[2].word   <= {ip_ttl, ip_proto_udp, 16'h0000};  // checksum slot zero
            words[3].word   <= board_ip;
            words[4].word   <= pc_ip;
            words[5].word   <= {board_port, pc_port};
            words[6].word   <= {udp_len, 16'h0000};                // udp checksum unused
        end else if (ck_step[2]) begin
            words[2].half[0] <= ~(csum[15:0] + 16'(csum[19:16]));  // second fold
        end
    end

    // ones-complement sum over the ip header halves
    always_comb begin
        sum_all = '0;
        for (int i = 0; i < ip_hdr_bytes / 4; i++) begin
            sum_all = sum_all + 20'(words[i].half[1]) + 20'(words[i].half[0]);
        end
    end

    always_ff @(posedge sys_clk) begin
        if (ck_step[0]) begin
            csum <= sum_all;
        end else if (ck_step[1]) begin
            csum <= 20'(csum[15:0]) + 20'(csum[19:16]);  // first fold
        end
    end

    assign hdr.hdr_word = words[hdr.hdr_idx];

endmodule

// File: verilog/udp_frame_seq.sv
module udp_frame_seq import udp_tx_pkg::*; #(
    parameter logic [47:0] board_mac = 48'h00_0a_35_01_fe_c0,
    parameter logic [47:0] pc_mac    = 48'hff_ff_ff_ff_ff_ff
) (
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  logic        send_en,
    input  logic [31:0] send_data,
    udp_hdr_if.seq      hdr,
    udp_crc_if.seq      crc,
    output logic        read_data_req,
    output logic        eth_tx_en,
    output logic        send_end,
    output logic [3:0]  eth_tx_data
);

    // dest mac, src mac, ethertype in wire order
    localparam logic [8*eth_hdr_bytes-1:0] eth_hdr_vec = {pc_mac, board_mac, eth_type_ipv4};
    localparam len_t hdr_len = len_t'(ip_hdr_bytes + udp_hdr_bytes);

    frame_state_e state;
    frame_state_e next_state;
    logic         send_en_d;
    logic         rise;
    logic         nib;        // 0 = low nibble of the byte
    len_t         byte_cnt;   // byte within the current section
    len_t         sec_len;
    len_t         pad_len;
    logic         sec_last;
    logic         tx_active;
    logic         req_now;
    logic         word_load;
    logic [31:0]  data_word;  // payload word being sent
    logic [7:0]   tx_byte;
    logic [3:0]   tx_nibble;
    logic [3:0]   fcs_bits;

    assign rise = send_en && !send_en_d;

    assign pad_len = (hdr.payload_len >= len_t'(min_payload_bytes)) ?
                     hdr.payload_len : len_t'(min_payload_bytes);

    //////////////////////////////////////////////////
    // state and counters

    always_comb begin
        case (state)
            preamble:   sec_len = len_t'(preamble_bytes);
            eth_hdr:    sec_len = len_t'(eth_hdr_bytes);
            ip_udp_hdr: sec_len = hdr_len;
            payload:    sec_len = pad_len;
            fcs:        sec_len = len_t'(fcs_nibbles / 2);
            default:    sec_len = len_t'(1);
        endcase
    end

    assign sec_last = nib && (byte_cnt == sec_len - len_t'(1));

    always_comb begin
        next_state = state;
        case (state)
            idle:       if (rise) next_state = checksum;
            checksum:   if (hdr.hdr_ready) next_state = preamble;
            preamble:   if (sec_last) next_state = eth_hdr;
            eth_hdr:    if (sec_last) next_state = ip_udp_hdr;
            ip_udp_hdr: if (sec_last) next_state = payload;
            payload:    if (sec_last) next_state = fcs;
            fcs:        if (sec_last) next_state = idle;
            default:    next_state = idle;
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state     <= idle;
            send_en_d <= 1'b0;
            hdr.start <= 1'b0;
            nib       <= 1'b0;
            byte_cnt  <= '0;
        end else begin
            state     <= next_state;
            send_en_d <= send_en;
            hdr.start <= (state == idle) && rise;  // edges mid-frame are dropped
            if (state == idle || state == checksum || sec_last) begin
                nib      <= 1'b0;
                byte_cnt <= '0;
            end else begin
                nib <= !nib;
                if (nib) begin
                    byte_cnt <= byte_cnt + len_t'(1);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // payload fetch

    // ask for word w two bytes before it is due
    assign req_now = !nib && byte_cnt[1:0] == 2'd2 &&
                     ((state == ip_udp_hdr && byte_cnt == hdr_len - len_t'(2) &&
                       hdr.payload_len != '0) ||
                      (state == payload &&
                       {1'b0, byte_cnt} + 17'd2 < {1'b0, hdr.payload_len}));

    // take the new word as the previous one finishes
    assign word_load = (state == ip_udp_hdr && sec_last) ||
                       (state == payload && nib && byte_cnt[1:0] == 2'd3);

    always_ff @(posedge sys_clk) begin
        if (word_load) begin
            data_word <= send_data;
        end
    end

    //////////////////////////////////////////////////
    // nibble select

    assign hdr.hdr_idx = byte_cnt[4:2];
    assign fcs_bits = crc.crc_value[(fcs_nibbles - 1 - {byte_cnt[1:0], nib}) * 4 +: 4];

    always_comb begin
        tx_byte = '0;
        case (state)
            preamble: begin
                tx_byte = (byte_cnt == len_t'(preamble_bytes - 1)) ? sfd_byte : preamble_byte;
            end
            eth_hdr:    tx_byte = eth_hdr_vec[(eth_hdr_bytes - 1 - byte_cnt[3:0]) * 8 +: 8];
            ip_udp_hdr: tx_byte = hdr.hdr_word.bytes[3 - byte_cnt[1:0]];
            payload: begin
                if (byte_cnt < hdr.payload_len) begin  // zeros past the data
                    tx_byte = data_word[(3 - byte_cnt[1:0]) * 8 +: 8];
                end
            end
            default:    tx_byte = '0;
        endcase
        tx_nibble = nib ? tx_byte[7:4] : tx_byte[3:0];
        if (state == fcs) begin
            tx_nibble = ~{fcs_bits[0], fcs_bits[1], fcs_bits[2], fcs_bits[3]};
        end
    end

    assign tx_active = (state != idle) && (state != checksum);

    // crc covers dest mac through padding
    assign crc.crc_clr    = hdr.start;
    assign crc.crc_en     = (state == eth_hdr) || (state == ip_udp_hdr) || (state == payload);
    assign crc.crc_nibble = tx_nibble;

    //////////////////////////////////////////////////
    // outputs

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            eth_tx_en     <= 1'b0;
            eth_tx_data   <= '0;
            read_data_req <= 1'b0;
            send_end      <= 1'b0;
        end else begin
            eth_tx_en     <= tx_active;
            eth_tx_data   <= tx_nibble;
            read_data_req <= req_now;
            send_end      <= eth_tx_en && !tx_active;  // last nibble just left
        end
    end

endmodule

// File: verilog/eth_crc32_d4.sv
module eth_crc32_d4 import udp_tx_pkg::*; (
    input  logic   sys_clk,
    input  logic   sys_rst_n,
    udp_crc_if.crc crc
);

    logic [31:0] crc_reg;
    logic [31:0] crc_step;

    //////////////////////////////////////////////////
    // four bits per clock

    // msb-first register, data bits in wire order
    always_comb begin
        crc_step = crc_reg;
        for (int i = 0; i < 4; i++) begin
            if (crc_step[31] ^ crc.crc_nibble[i]) begin
                crc_step = {crc_step[30:0], 1'b0} ^ crc_poly;
            end else begin
                crc_step = {crc_step[30:0], 1'b0};
            end
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            crc_reg <= crc_init;
        end else if (crc.crc_clr) begin
            crc_reg <= crc_init;   // new frame
        end else if (crc.crc_en) begin
            crc_reg <= crc_step;
        end
    end

    // fcs is the complement, taken by the sequencer
    assign crc.crc_value = crc_reg;

endmodule

// File: verilog/udp_tx_top.sv
module udp_tx_top import udp_tx_pkg::*; #(
    parameter logic [47:0] board_mac  = 48'h00_0a_35_01_fe_c0,
    parameter logic [31:0] board_ip   = 32'hc0a8_0002,  // 192.168.0.2
    parameter logic [15:0] board_port = 16'd1234,
    parameter logic [47:0] pc_mac     = 48'hff_ff_ff_ff_ff_ff,
    parameter logic [31:0] pc_ip      = 32'hc0a8_0001,
    parameter logic [15:0] pc_port    = 16'd1234
) (
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  logic        send_en,
    input  logic [31:0] send_data,
    input  len_t        send_data_num,
    output logic        send_end,
    output logic        read_data_req,
    output logic        eth_tx_en,
    output logic [3:0]  eth_tx_data
);

    udp_hdr_if u_hdr_if ();
    udp_crc_if u_crc_if ();

    // ip and udp header words, checksum
    udp_hdr_regs #(
        .board_ip   (board_ip),
        .pc_ip      (pc_ip),
        .board_port (board_port),
        .pc_port    (pc_port)
    ) u_hdr_regs (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .send_data_num (send_data_num),
        .hdr           (u_hdr_if.regs)
    );

    udp_frame_seq #(
        .board_mac (board_mac),
        .pc_mac    (pc_mac)
    ) u_frame_seq (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .send_en       (send_en),
        .send_data     (send_data),
        .hdr           (u_hdr_if.seq),
        .crc           (u_crc_if.seq),
        .read_data_req (read_data_req),
        .eth_tx_en     (eth_tx_en),
        .send_end      (send_end),
        .eth_tx_data   (eth_tx_data)
    );

    eth_crc32_d4 u_crc (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .crc       (u_crc_if.crc)
    );

endmodule

// File: verification/udp_tx_tb.sv
module udp_tx_tb import udp_tx_pkg::*; ();

    // addresses differ from the dut defaults
    localparam logic [47:0] board_mac  = 48'h02_11_22_33_44_55;
    localparam logic [31:0] board_ip   = 32'h0a00_0005;
    localparam logic [15:0] board_port = 16'd5001;
    localparam logic [47:0] pc_mac     = 48'h02_aa_bb_cc_dd_ee;
    localparam logic [31:0] pc_ip      = 32'h0a00_0001;
    localparam logic [15:0] pc_port    = 16'd6002;
    localparam int          num_random = 40;

    logic        sys_clk;
    logic        sys_rst_n;
    logic        send_en;
    logic [31:0] send_data;
    len_t        send_data_num;
    logic        send_end;
    logic        read_data_req;
    logic        eth_tx_en;
    logic [3:0]  eth_tx_data;

    logic [31:0] fifo_words [$];  // payload words of the current frame
    logic [3:0]  rx_nibbles [$];
    logic [7:0]  rx_bytes [$];
    logic [7:0]  exp_bytes [$];
    int          fixed_lens [5];
    int          word_idx;
    bit          req_seen;
    int          req_cnt;
    int          end_cnt;
    int          errors;
    int          checks;
    int          frames;
    bit          aborted;
    logic [15:0] exp_ident;

    udp_tx_top #(
        .board_mac  (board_mac),
        .board_ip   (board_ip),
        .board_port (board_port),
        .pc_mac     (pc_mac),
        .pc_ip      (pc_ip),
        .pc_port    (pc_port)
    ) u_dut (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .send_en       (send_en),
        .send_data     (send_data),
        .send_data_num (send_data_num),
        .send_end      (send_end),
        .read_data_req (read_data_req),
        .eth_tx_en     (eth_tx_en),
        .eth_tx_data   (eth_tx_data)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    //////////////////////////////////////////////////
    // helpers

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    // one falling edge, fifo model and pulse counters
    task automatic tick();
        @(negedge sys_clk);
        if (req_seen) begin
            if (word_idx < fifo_words.size()) begin
                send_data = fifo_words[word_idx];
            end
            word_idx++;
        end
        req_seen = read_data_req;
        if (read_data_req) req_cnt++;
        if (send_end) end_cnt++;
    endtask

    function automatic logic [31:0] crc_update(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] r;
        r = c ^ {24'h0, b};
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ 32'hedb8_8320) : (r >> 1);  // reflected poly
        end
        return r;
    endfunction

    // ones-complement sum of ten halves from base
    function automatic logic [15:0] ones_sum(input logic [7:0] q [$], input int base);
        logic [19:0] s;
        s = '0;
        for (int i = 0; i < 10; i++) begin
            s = s + {q[base + 2 * i], q[base + 2 * i + 1]};
        end
        s = s[15:0] + s[19:16];
        s = s[15:0] + s[19:16];
        return s[15:0];
    endfunction

    function automatic string region(input int i, input int pad);
        string r;
        if (i < 8) r = "preamble";
        else if (i < 22) r = "eth header";
        else if (i < 42) r = "ip header";
        else if (i < 50) r = "udp header";
        else if (i < 50 + pad) r = "payload";
        else r = "fcs";
        return r;
    endfunction

    task automatic push_word(input logic [31:0] w);
        for (int b = 3; b >= 0; b--) exp_bytes.push_back(w[b * 8 +: 8]);
    endtask

    //////////////////////////////////////////////////
    // reference model

    task automatic build_expected(input int n, input int pad);
        logic [15:0] ck;
        logic [31:0] c;
        exp_bytes.delete();
        repeat (7) exp_bytes.push_back(8'h55);
        exp_bytes.push_back(8'hd5);
        for (int i = 5; i >= 0; i--) exp_bytes.push_back(pc_mac[i * 8 +: 8]);  // dest first
        for (int i = 5; i >= 0; i--) exp_bytes.push_back(board_mac[i * 8 +: 8]);
        exp_bytes.push_back(8'h08);
        exp_bytes.push_back(8'h00);
        push_word({8'h45, 8'h00, 16'(n + 28)});
        push_word({exp_ident, 16'h4000});
        push_word({8'h40, 8'd17, 16'h0000});
        push_word(board_ip);
        push_word(pc_ip);
        push_word({board_port, pc_port});
        push_word({16'(n + 8), 16'h0000});  // udp checksum stays zero
        ck = ~ones_sum(exp_bytes, 22);
        exp_bytes[32] = ck[15:8];
        exp_bytes[33] = ck[7:0];
        for (int i = 0; i < pad; i++) begin
            if (i < n) exp_bytes.push_back(fifo_words[i / 4][(3 - i % 4) * 8 +: 8]);
            else exp_bytes.push_back(8'h00);
        end
        c = 32'hffff_ffff;
        for (int i = 8; i < exp_bytes.size(); i++) c = crc_update(c, exp_bytes[i]);
        c = ~c;
        for (int b = 0; b < 4; b++) exp_bytes.push_back(c[b * 8 +: 8]);  // fcs lsb byte first
    endtask

    //////////////////////////////////////////////////
    // one frame

    task automatic run_frame(input int n);
        string name;
        int    pad;
        int    wait_cnt;
        int    nbytes;
        name = $sformatf("frame %0d n=%0d", frames, n);
        pad = (n > 18) ? n : 18;
        fifo_words.delete();
        for (int i = 0; i < (n + 3) / 4; i++) fifo_words.push_back($urandom);
        word_idx   = 0;
        req_seen   = 1'b0;
        req_cnt    = 0;
        end_cnt    = 0;
        rx_nibbles.delete();
        rx_bytes.delete();
        exp_ident  = exp_ident + 16'd1;
        build_expected(n, pad);

        send_data_num = len_t'(n);
        send_en       = 1'b1;
        tick();
        send_en = 1'b0;

        wait_cnt = 0;
        while (!eth_tx_en && wait_cnt < 50) begin
            tick();
            wait_cnt++;
        end
        if (!eth_tx_en) begin
            $display("timeout: %s never raised eth_tx_en", name);
            errors++;
            aborted = 1'b1;
            return;
        end
        wait_cnt = 0;
        while (eth_tx_en && wait_cnt < 400) begin
            rx_nibbles.push_back(eth_tx_data);
            tick();
            wait_cnt++;
        end
        if (eth_tx_en) begin
            $display("timeout: %s kept eth_tx_en high too long", name);
            errors++;
            aborted = 1'b1;
            return;
        end
        check_value({name, " send_end at tx_en fall"}, 1, send_end);
        repeat (4) begin
            tick();
            check_value({name, " tx_en low after frame"}, 0, eth_tx_en);
        end

        check_value({name, " nibble count"}, 2 * (50 + pad) + 8, rx_nibbles.size());
        check_value({name, " read_data_req pulses"}, (n + 3) / 4, req_cnt);
        check_value({name, " send_end pulses"}, 1, end_cnt);

        // low nibble first on the wire
        for (int i = 0; i + 1 < rx_nibbles.size(); i += 2) begin
            rx_bytes.push_back({rx_nibbles[i + 1], rx_nibbles[i]});
        end
        nbytes = (rx_bytes.size() < exp_bytes.size()) ? rx_bytes.size() : exp_bytes.size();
        for (int i = 0; i < nbytes; i++) begin
            check_value($sformatf("%s %s byte %0d", name, region(i, pad), i),
                        exp_bytes[i], rx_bytes[i]);
        end
        if (rx_bytes.size() >= 42) begin
            check_value({name, " identification"}, exp_ident, {rx_bytes[26], rx_bytes[27]});
            check_value({name, " ip header sum"}, 16'hffff, ones_sum(rx_bytes, 22));
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        int n;
        sys_rst_n     = 1'b0;
        send_en       = 1'b0;
        send_data     = '0;
        send_data_num = '0;
        errors        = 0;
        checks        = 0;
        frames        = 0;
        aborted       = 1'b0;
        exp_ident     = '0;
        word_idx      = 0;
        req_seen      = 1'b0;
        req_cnt       = 0;
        end_cnt       = 0;
        fixed_lens    = '{1, 17, 18, 19, 4};
        void'($urandom(40947));

        repeat (16) begin
            @(negedge sys_clk);
            check_value("reset outputs", 0, {send_end, read_data_req, eth_tx_en, eth_tx_data,
                        u_dut.u_hdr_if.start, u_dut.u_hdr_if.hdr_ready,
                        u_dut.u_crc_if.crc_en});
            check_value("reset identification", 0, u_dut.u_hdr_regs.ident);
        end
        sys_rst_n = 1'b1;
        repeat (3) tick();

        for (int i = 0; i < 5 + num_random; i++) begin
            if (!aborted) begin
                n = (i < 5) ? fixed_lens[i] : $urandom_range(64, 1);
                frames++;
                run_frame(n);
                repeat (2) tick();  // send_en low between frames
            end
        end

        $display("frames %0d, checks %0d, errors %0d", frames, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: udp_tx_top.f
verilog/udp_tx_pkg.sv
verilog/udp_hdr_if.sv
verilog/udp_crc_if.sv
verilog/udp_hdr_regs.sv
verilog/udp_frame_seq.sv
verilog/eth_crc32_d4.sv
verilog/udp_tx_top.sv
verification/udp_tx_tb.sv

// File: Bender.yml
package:
  name: udp_tx

sources:
  # rtl in compile order
  - files:
      - verilog/udp_tx_pkg.sv
      - verilog/udp_hdr_if.sv
      - verilog/udp_crc_if.sv
      - verilog/udp_hdr_regs.sv
      - verilog/udp_frame_seq.sv
      - verilog/eth_crc32_d4.sv
      - verilog/udp_tx_top.sv

  - target: test
    files:
      - verification/udp_tx_tb.sv
